/* monsterPkg.sv */
package monsterPkg;

    // Screen coordinate, also used for sprite offsets
    typedef logic [10:0] coordT;

    typedef logic [7:0] colorT;

    typedef logic [2:0] stageT;

    typedef enum logic [1:0] {
        LIFE_INACTIVE,
        LIFE_ALIVE,
        LIFE_EXPLODING,
        LIFE_DEAD
    } lifeStateT;

    // Monster square and the corner blocks cut out of it
    localparam int SPRITE_SIZE = 16;
    localparam int CORNER_SIZE = 4;

    localparam int SCREEN_W = 640;
    localparam int SCREEN_H = 480;

    // Fixed colors per life state
    localparam colorT ALIVE_COLOR = 8'hE0;
    localparam colorT EXPLODE_COLOR = 8'hFC;
    localparam colorT MISSILE_COLOR = 8'hD0;

    // Missile rectangle
    localparam int MISSILE_W = 2;
    localparam int MISSILE_H = 6;

endpackage

/* frameTimer.sv */
`timescale 1ns/1ns

module frameTimer #(
    parameter int FRAMES = 3
) (
    input  logic clk,
    input  logic resetN,
    input  logic run,
    input  logic frameTick,
    output logic done
);

    localparam int COUNT_W = $clog2(FRAMES + 1);

    logic [COUNT_W-1:0] count;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            count <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!run) begin
                count <= '0;
            end else if (frameTick) begin
                // Last frame of the interval restarts the count
                if (count == COUNT_W'(FRAMES - 1)) begin
                    count <= '0;
                    done <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    countInRange: assert property (@(posedge clk) disable iff (!resetN)
        count < COUNT_W'(FRAMES));

endmodule

/* monsterLife.sv */
`timescale 1ns/1ns

module monsterLife
    import monsterPkg::*;
(
    input  logic      clk,
    input  logic      resetN,
    input  logic      active,
    input  logic      hit,
    input  logic      explodeDone,
    output lifeStateT state
);

    lifeStateT nextState;

    always_comb begin
        nextState = state;
        case (state)
            LIFE_INACTIVE: begin
                if (active) begin
                    nextState = LIFE_ALIVE;
                end
            end
            LIFE_ALIVE: begin
                // Stage change can take a living monster out of play
                if (!active) begin
                    nextState = LIFE_INACTIVE;
                end else if (hit) begin
                    nextState = LIFE_EXPLODING;
                end
            end
            LIFE_EXPLODING: begin
                if (explodeDone) begin
                    nextState = LIFE_DEAD;
                end
            end
            default: begin
                nextState = LIFE_DEAD;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state <= LIFE_INACTIVE;
        end else begin
            state <= nextState;
        end
    end

    explodeFromAlive: assert property (@(posedge clk) disable iff (!resetN)
        (state == LIFE_EXPLODING && $past(state) != LIFE_EXPLODING)
        |-> $past(state) == LIFE_ALIVE);

endmodule

/* monsterMotion.sv */
`timescale 1ns/1ns

module monsterMotion
    import monsterPkg::*;
#(
    parameter int INIT_X = 100,
    parameter int INIT_Y = 50,
    parameter int X_SPEED = 4,
    parameter int Y_SPEED = 2
) (
    input  logic  clk,
    input  logic  resetN,
    input  logic  frameTick,
    output coordT posX,
    output coordT posY
);

    localparam int MAX_X = SCREEN_W - SPRITE_SIZE;
    localparam int MAX_Y = SCREEN_H - SPRITE_SIZE;

    logic signed [11:0] velX;
    logic signed [11:0] velY;
    logic signed [12:0] nextX;
    logic signed [12:0] nextY;
    logic bounceX;
    logic bounceY;

    // Candidate step, rejected when it leaves the screen
    always_comb begin
        nextX = $signed({2'b00, posX}) + 13'(velX);
        nextY = $signed({2'b00, posY}) + 13'(velY);
        bounceX = (nextX < 0) || (nextX > MAX_X);
        bounceY = (nextY < 0) || (nextY > MAX_Y);
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            posX <= coordT'(INIT_X);
            posY <= coordT'(INIT_Y);
            velX <= 12'(X_SPEED);
            velY <= 12'(Y_SPEED);
        end else if (frameTick) begin
            if (bounceX) begin
                velX <= -velX;
            end else begin
                posX <= nextX[10:0];
            end
            if (bounceY) begin
                velY <= -velY;
            end else begin
                posY <= nextY[10:0];
            end
        end
    end

    posOnScreen: assert property (@(posedge clk) disable iff (!resetN)
        posX <= coordT'(MAX_X) && posY <= coordT'(MAX_Y));

endmodule

/* spriteWindow.sv */
`timescale 1ns/1ns

module spriteWindow
    import monsterPkg::*;
(
    input  logic  clk,
    input  logic  resetN,
    input  coordT pixelX,
    input  coordT pixelY,
    input  coordT posX,
    input  coordT posY,
    output logic  inSprite
);

    coordT offsetX;
    coordT offsetY;
    logic inSquare;
    logic cornerX;
    logic cornerY;
    logic inSilhouette;

    always_comb begin
        // Pixels left of or above the sprite wrap to large offsets
        offsetX = pixelX - posX;
        offsetY = pixelY - posY;
        inSquare = (offsetX < coordT'(SPRITE_SIZE)) && (offsetY < coordT'(SPRITE_SIZE));
        cornerX = (offsetX < coordT'(CORNER_SIZE))
            || (offsetX >= coordT'(SPRITE_SIZE - CORNER_SIZE));
        cornerY = (offsetY < coordT'(CORNER_SIZE))
            || (offsetY >= coordT'(SPRITE_SIZE - CORNER_SIZE));
        inSilhouette = inSquare && !(cornerX && cornerY);
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            inSprite <= 1'b0;
        end else begin
            inSprite <= inSilhouette;
        end
    end

endmodule

/* monsterMissiles.sv */
`timescale 1ns/1ns

module monsterMissiles
    import monsterPkg::*;
#(
    parameter int SHOT_COUNT = 2,
    parameter int MISSILE_SPEED = 16
) (
    input  logic  clk,
    input  logic  resetN,
    input  logic  fire,
    input  logic  frameTick,
    input  logic  playerHit,
    input  coordT pixelX,
    input  coordT pixelY,
    input  coordT originX,
    input  coordT originY,
    output logic  missileDraw
);

    logic [SHOT_COUNT-1:0] valid;
    logic [SHOT_COUNT-1:0] launch;
    logic [SHOT_COUNT-1:0] slotCover;
    logic [SHOT_COUNT-1:0] slotDraw;
    logic [SHOT_COUNT-1:0] slotPrev;
    logic freeFound;
    coordT missX [SHOT_COUNT];
    coordT missY [SHOT_COUNT];
    logic [11:0] fallY [SHOT_COUNT];

    // Lowest free slot takes the fire pulse, none free drops it
    always_comb begin
        launch = '0;
        freeFound = 1'b0;
        for (int s = 0; s < SHOT_COUNT; s++) begin
            if (!valid[s] && !freeFound) begin
                launch[s] = fire;
                freeFound = 1'b1;
            end
        end
    end

    always_comb begin
        for (int s = 0; s < SHOT_COUNT; s++) begin
            fallY[s] = {1'b0, missY[s]} + 12'(MISSILE_SPEED);
            slotCover[s] = valid[s]
                && ((pixelX - missX[s]) < coordT'(MISSILE_W))
                && ((pixelY - missY[s]) < coordT'(MISSILE_H));
        end
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            valid <= '0;
            slotDraw <= '0;
            slotPrev <= '0;
        end else begin
            slotDraw <= slotCover;
            slotPrev <= slotDraw;
            for (int s = 0; s < SHOT_COUNT; s++) begin
                if (launch[s]) begin
                    valid[s] <= 1'b1;
                end else if (playerHit && slotPrev[s]) begin
                    valid[s] <= 1'b0;
                end else if (frameTick && fallY[s] >= 12'(SCREEN_H)) begin
                    valid[s] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < SHOT_COUNT; s++) begin
            if (launch[s]) begin
                // Leave from the bottom center of the monster
                missX[s] <= originX + coordT'(SPRITE_SIZE / 2);
                missY[s] <= originY + coordT'(SPRITE_SIZE);
            end else if (frameTick && valid[s]) begin
                missY[s] <= fallY[s][10:0];
            end
        end
    end

    assign missileDraw = |slotDraw;

endmodule

/* monsterGroup.sv */
`timescale 1ns/1ns

module monsterGroup
    import monsterPkg::*;
#(
    parameter int MONSTER_COUNT = 3,
    parameter int EXPLODE_FRAMES = 3,
    parameter int COOLDOWN_BASE = 8,
    parameter int SHOT_COUNT = 2,
    parameter int MISSILE_SPEED = 16,
    parameter int X_SPEED_BASE = 4,
    parameter int Y_SPEED_BASE = 2,
    parameter int INITIAL_X = 100,
    parameter int X_SPACING = 64,
    parameter int INITIAL_Y = 50
) (
    input  logic  clk,
    input  logic  resetN,
    input  logic  enable,
    input  logic  startOfFrame,
    input  stageT stage,
    input  logic  shotHit,
    input  logic  playerHit,
    input  coordT pixelX,
    input  coordT pixelY,
    output logic  monsterDraw,
    output colorT monsterColor,
    output logic  missileDraw,
    output colorT missileColor,
    output logic  diedPulse,
    output logic  allDead
);

    localparam int COUNT_W = $clog2(MONSTER_COUNT + 1);

    logic [COUNT_W-1:0] activeCount;
    logic [MONSTER_COUNT-1:0] active;
    logic [MONSTER_COUNT-1:0] frameTick;
    logic [MONSTER_COUNT-1:0] inSprite;
    logic [MONSTER_COUNT-1:0] alive;
    logic [MONSTER_COUNT-1:0] exploding;
    logic [MONSTER_COUNT-1:0] drawReq;
    logic [MONSTER_COUNT-1:0] prevDraw;
    logic [MONSTER_COUNT-1:0] hit;
    logic [MONSTER_COUNT-1:0] explodeDone;
    logic [MONSTER_COUNT-1:0] fire;
    logic [MONSTER_COUNT-1:0] gone;
    logic [MONSTER_COUNT-1:0] shotDraw;
    coordT posX [MONSTER_COUNT];
    coordT posY [MONSTER_COUNT];
    lifeStateT lifeState [MONSTER_COUNT];

    // Stage 1 and the boss stage 4 field a single monster
    always_comb begin
        case (stage)
            3'd1: activeCount = COUNT_W'(1);
            3'd4: activeCount = COUNT_W'(1);
            default: activeCount = COUNT_W'(MONSTER_COUNT);
        endcase
    end

    for (genvar i = 0; i < MONSTER_COUNT; i++) begin : genMonster
        assign active[i] = COUNT_W'(i) < activeCount;
        assign frameTick[i] = startOfFrame & enable & active[i];
        assign alive[i] = lifeState[i] == LIFE_ALIVE;
        assign exploding[i] = lifeState[i] == LIFE_EXPLODING;
        assign drawReq[i] = inSprite[i] & (alive[i] | exploding[i]);
        assign hit[i] = shotHit & prevDraw[i] & alive[i];
        assign gone[i] = (lifeState[i] == LIFE_DEAD) | ~active[i];

        monsterMotion #(
            .INIT_X(INITIAL_X + i * X_SPACING),
            .INIT_Y(INITIAL_Y),
            .X_SPEED(X_SPEED_BASE + i),
            .Y_SPEED(Y_SPEED_BASE + i)
        ) motion (
            .clk(clk),
            .resetN(resetN),
            .frameTick(frameTick[i]),
            .posX(posX[i]),
            .posY(posY[i])
        );

        spriteWindow window (
            .clk(clk),
            .resetN(resetN),
            .pixelX(pixelX),
            .pixelY(pixelY),
            .posX(posX[i]),
            .posY(posY[i]),
            .inSprite(inSprite[i])
        );

        monsterLife life (
            .clk(clk),
            .resetN(resetN),
            .active(active[i]),
            .hit(hit[i]),
            .explodeDone(explodeDone[i]),
            .state(lifeState[i])
        );

        frameTimer #(.FRAMES(EXPLODE_FRAMES)) explodeTimer (
            .clk(clk),
            .resetN(resetN),
            .run(exploding[i]),
            .frameTick(frameTick[i]),
            .done(explodeDone[i])
        );

        frameTimer #(.FRAMES(COOLDOWN_BASE + i)) cooldownTimer (
            .clk(clk),
            .resetN(resetN),
            .run(alive[i]),
            .frameTick(frameTick[i]),
            .done(fire[i])
        );

        monsterMissiles #(
            .SHOT_COUNT(SHOT_COUNT),
            .MISSILE_SPEED(MISSILE_SPEED)
        ) missiles (
            .clk(clk),
            .resetN(resetN),
            .fire(fire[i]),
            .frameTick(frameTick[i]),
            .playerHit(playerHit),
            .pixelX(pixelX),
            .pixelY(pixelY),
            .originX(posX[i]),
            .originY(posY[i]),
            .missileDraw(shotDraw[i])
        );
    end

    // Previous draw requests feed the hit rule, a hit marks the death
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            prevDraw <= '0;
            diedPulse <= 1'b0;
        end else begin
            prevDraw <= drawReq;
            diedPulse <= |hit;
        end
    end

    // Walk down so the lowest index wins
    always_comb begin
        monsterDraw = 1'b0;
        monsterColor = ALIVE_COLOR;
        for (int j = MONSTER_COUNT - 1; j >= 0; j--) begin
            if (drawReq[j]) begin
                monsterDraw = 1'b1;
                monsterColor = alive[j] ? ALIVE_COLOR : EXPLODE_COLOR;
            end
        end
    end

    assign allDead = &gone;
    assign missileDraw = |shotDraw;
    assign missileColor = MISSILE_COLOR;

endmodule

/* monsterGroupTb.sv */
`timescale 1ns/1ns

module monsterGroupTb
    import monsterPkg::*;
();

    localparam int MONSTERS = 3;
    localparam int EXPLODE_FRAMES = 3;
    localparam int COOLDOWN_BASE = 8;
    localparam int SHOTS = 2;
    localparam int MISSILE_SPEED = 16;
    localparam int X_SPEED_BASE = 4;
    localparam int Y_SPEED_BASE = 2;
    localparam int INITIAL_X = 100;
    localparam int X_SPACING = 64;
    localparam int INITIAL_Y = 50;
    localparam int CLK_PERIOD = 40;
    localparam int SEED = 67889;
    localparam int FRAME_CYCLES = 4;
    localparam int MOVE_FRAMES = 120;
    localparam int FRAME_TOTAL = MOVE_FRAMES + 10;
    localparam int PROBES_PER_FRAME = 12;
    localparam int WATCHDOG_NS =
        (FRAME_TOTAL * (FRAME_CYCLES + 2 * PROBES_PER_FRAME) + 1000) * CLK_PERIOD;

    logic clk;
    logic resetN;
    logic enable;
    logic startOfFrame;
    stageT stage;
    logic shotHit;
    logic playerHit;
    coordT pixelX;
    coordT pixelY;
    logic monsterDraw;
    colorT monsterColor;
    logic missileDraw;
    colorT missileColor;
    logic diedPulse;
    logic allDead;

    // Expected values for the next rising edge
    logic checkEn;
    logic expDraw;
    colorT expColor;
    logic expMissile;
    logic expDied;
    logic expAllDead;

    // Reference model of the monsters
    int modelStage;
    int modelX [MONSTERS];
    int modelY [MONSTERS];
    int velX [MONSTERS];
    int velY [MONSTERS];
    lifeStateT modelLife [MONSTERS];
    int explodeCount [MONSTERS];
    int coolCount [MONSTERS];
    logic slotValid [MONSTERS][SHOTS];
    int slotX [MONSTERS][SHOTS];
    int slotY [MONSTERS][SHOTS];
    logic bounceSeen;

    monsterGroup #(
        .MONSTER_COUNT(MONSTERS),
        .EXPLODE_FRAMES(EXPLODE_FRAMES),
        .COOLDOWN_BASE(COOLDOWN_BASE),
        .SHOT_COUNT(SHOTS),
        .MISSILE_SPEED(MISSILE_SPEED),
        .X_SPEED_BASE(X_SPEED_BASE),
        .Y_SPEED_BASE(Y_SPEED_BASE),
        .INITIAL_X(INITIAL_X),
        .X_SPACING(X_SPACING),
        .INITIAL_Y(INITIAL_Y)
    ) monsterGroup_i (
        .clk(clk),
        .resetN(resetN),
        .enable(enable),
        .startOfFrame(startOfFrame),
        .stage(stage),
        .shotHit(shotHit),
        .playerHit(playerHit),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .monsterDraw(monsterDraw),
        .monsterColor(monsterColor),
        .missileDraw(missileDraw),
        .missileColor(missileColor),
        .diedPulse(diedPulse),
        .allDead(allDead)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    task automatic reportMismatch(input string name, input int got, input int want);
        $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
        $display("Test failures found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic failRun(input string reason);
        $display("error at %0t ns: %s", $time, reason);
        $display("Test failures found");
        $fatal(1, "stopping at the first error");
    endtask

    drawCheck: assert property (@(posedge clk) checkEn |-> monsterDraw == expDraw)
        else reportMismatch("monsterDraw", int'($sampled(monsterDraw)), int'($sampled(expDraw)));
    colorCheck: assert property (@(posedge clk) checkEn && expDraw |-> monsterColor == expColor)
        else reportMismatch("monsterColor", int'($sampled(monsterColor)),
            int'($sampled(expColor)));
    missileCheck: assert property (@(posedge clk) checkEn |-> missileDraw == expMissile)
        else reportMismatch("missileDraw", int'($sampled(missileDraw)),
            int'($sampled(expMissile)));
    missileColorCheck: assert property (@(posedge clk) checkEn |-> missileColor == 8'hD0)
        else reportMismatch("missileColor", int'($sampled(missileColor)), 'hD0);
    diedCheck: assert property (@(posedge clk) checkEn |-> diedPulse == expDied)
        else reportMismatch("diedPulse", int'($sampled(diedPulse)), int'($sampled(expDied)));
    allDeadCheck: assert property (@(posedge clk) checkEn |-> allDead == expAllDead)
        else reportMismatch("allDead", int'($sampled(allDead)), int'($sampled(expAllDead)));

    function automatic int activeCountFor(input int s);
        if (s == 1 || s == 4) begin
            return 1;
        end
        return MONSTERS;
    endfunction

    // Square minus the four corner blocks
    function automatic logic silhouette(input int px, input int py, input int i);
        int dx;
        int dy;
        logic cornerX;
        logic cornerY;
        dx = px - modelX[i];
        dy = py - modelY[i];
        if (dx < 0 || dy < 0 || dx >= 16 || dy >= 16) begin
            return 1'b0;
        end
        cornerX = dx < 4 || dx >= 12;
        cornerY = dy < 4 || dy >= 12;
        return !(cornerX && cornerY);
    endfunction

    function automatic logic missileAt(input int px, input int py, input int i, input int s);
        return slotValid[i][s] && px >= slotX[i][s] && px < slotX[i][s] + 2
            && py >= slotY[i][s] && py < slotY[i][s] + 6;
    endfunction

    task automatic updateExpect(input int px, input int py);
        logic gone;
        expDraw = 1'b0;
        expColor = 8'hE0;
        expMissile = 1'b0;
        gone = 1'b1;
        for (int i = MONSTERS - 1; i >= 0; i--) begin
            if ((modelLife[i] == LIFE_ALIVE || modelLife[i] == LIFE_EXPLODING)
                    && silhouette(px, py, i)) begin
                expDraw = 1'b1;
                expColor = (modelLife[i] == LIFE_ALIVE) ? 8'hE0 : 8'hFC;
            end
            for (int s = 0; s < SHOTS; s++) begin
                if (missileAt(px, py, i, s)) begin
                    expMissile = 1'b1;
                end
            end
            if (modelLife[i] != LIFE_DEAD && i < activeCountFor(modelStage)) begin
                gone = 1'b0;
            end
        end
        expAllDead = gone;
    endtask

    task automatic modelFrame();
        int nx;
        int ny;
        logic launched;
        for (int i = 0; i < activeCountFor(modelStage); i++) begin
            nx = modelX[i] + velX[i];
            ny = modelY[i] + velY[i];
            if (nx < 0 || nx > 624) begin
                velX[i] = -velX[i];
                bounceSeen = 1'b1;
            end else begin
                modelX[i] = nx;
            end
            if (ny < 0 || ny > 464) begin
                velY[i] = -velY[i];
                bounceSeen = 1'b1;
            end else begin
                modelY[i] = ny;
            end
            for (int s = 0; s < SHOTS; s++) begin
                if (slotValid[i][s]) begin
                    if (slotY[i][s] + MISSILE_SPEED >= 480) begin
                        slotValid[i][s] = 1'b0;
                    end else begin
                        slotY[i][s] += MISSILE_SPEED;
                    end
                end
            end
            if (modelLife[i] == LIFE_EXPLODING) begin
                explodeCount[i]++;
                if (explodeCount[i] == EXPLODE_FRAMES) begin
                    modelLife[i] = LIFE_DEAD;
                end
            end else if (modelLife[i] == LIFE_ALIVE) begin
                coolCount[i]++;
                if (coolCount[i] == COOLDOWN_BASE + i) begin
                    coolCount[i] = 0;
                    launched = 1'b0;
                    // Lowest free slot takes the missile or the pulse is dropped
                    for (int s = 0; s < SHOTS; s++) begin
                        if (!slotValid[i][s] && !launched) begin
                            slotValid[i][s] = 1'b1;
                            slotX[i][s] = modelX[i] + 8;
                            slotY[i][s] = modelY[i] + 16;
                            launched = 1'b1;
                        end
                    end
                end
            end
        end
    endtask

    task automatic probe(input int px, input int py);
        if (px < 0) px = 0;
        if (py < 0) py = 0;
        if (px > 639) px = 639;
        if (py > 479) py = 479;
        @(negedge clk);
        checkEn = 1'b0;
        pixelX = coordT'(px);
        pixelY = coordT'(py);
        @(negedge clk);
        updateExpect(px, py);
        checkEn = 1'b1;
    endtask

    task automatic probeRandom();
        int i;
        i = int'($urandom % MONSTERS);
        probe(modelX[i] + int'($urandom % 24) - 4, modelY[i] + int'($urandom % 24) - 4);
    endtask

    task automatic probeFrame();
        for (int i = 0; i < MONSTERS; i++) begin
            probe(modelX[i] + 8, modelY[i] + 8);
            for (int s = 0; s < SHOTS; s++) begin
                if (slotValid[i][s]) begin
                    probe(slotX[i][s], slotY[i][s]);
                end
            end
        end
        probeRandom();
    endtask

    task automatic frame();
        @(negedge clk);
        checkEn = 1'b0;
        startOfFrame = 1'b1;
        @(negedge clk);
        startOfFrame = 1'b0;
        if (enable) begin
            modelFrame();
        end
        repeat (FRAME_CYCLES - 1) @(negedge clk);
    endtask

    task automatic setStage(input int s);
        @(negedge clk);
        checkEn = 1'b0;
        stage = stageT'(s);
        modelStage = s;
        @(negedge clk);
        for (int i = 0; i < MONSTERS; i++) begin
            if (modelLife[i] == LIFE_INACTIVE && i < activeCountFor(s)) begin
                modelLife[i] = LIFE_ALIVE;
                coolCount[i] = 0;
            end else if (modelLife[i] == LIFE_ALIVE && i >= activeCountFor(s)) begin
                modelLife[i] = LIFE_INACTIVE;
                coolCount[i] = 0;
            end
        end
    endtask

    // Hit lands two cycles after the pixel and the pulse one cycle after that
    task automatic shoot(input int px, input int py);
        logic anyHit;
        @(negedge clk);
        checkEn = 1'b0;
        pixelX = coordT'(px);
        pixelY = coordT'(py);
        repeat (2) @(negedge clk);
        shotHit = 1'b1;
        @(negedge clk);
        shotHit = 1'b0;
        anyHit = 1'b0;
        for (int i = 0; i < MONSTERS; i++) begin
            if (modelLife[i] == LIFE_ALIVE && silhouette(px, py, i)) begin
                modelLife[i] = LIFE_EXPLODING;
                explodeCount[i] = 0;
                coolCount[i] = 0;
                anyHit = 1'b1;
            end
        end
        updateExpect(px, py);
        expDied = anyHit;
        checkEn = 1'b1;
        @(negedge clk);
        expDied = 1'b0;
        @(negedge clk);
        checkEn = 1'b0;
    endtask

    task automatic hitMissile(input int px, input int py);
        @(negedge clk);
        checkEn = 1'b0;
        pixelX = coordT'(px);
        pixelY = coordT'(py);
        repeat (2) @(negedge clk);
        playerHit = 1'b1;
        @(negedge clk);
        playerHit = 1'b0;
        for (int i = 0; i < MONSTERS; i++) begin
            for (int s = 0; s < SHOTS; s++) begin
                if (missileAt(px, py, i, s)) begin
                    slotValid[i][s] = 1'b0;
                end
            end
        end
    endtask

    initial begin
        int hitX;
        int hitY;
        logic found;
        void'($urandom(SEED));
        resetN = 1'b0;
        enable = 1'b0;
        startOfFrame = 1'b0;
        stage = stageT'(2);
        shotHit = 1'b0;
        playerHit = 1'b0;
        pixelX = coordT'(INITIAL_X + 8);
        pixelY = coordT'(INITIAL_Y + 8);
        checkEn = 1'b0;
        expDraw = 1'b0;
        expColor = 8'hE0;
        expMissile = 1'b0;
        expDied = 1'b0;
        expAllDead = 1'b0;
        bounceSeen = 1'b0;
        modelStage = 2;
        for (int i = 0; i < MONSTERS; i++) begin
            modelX[i] = INITIAL_X + i * X_SPACING;
            modelY[i] = INITIAL_Y;
            velX[i] = X_SPEED_BASE + i;
            velY[i] = Y_SPEED_BASE + i;
            modelLife[i] = LIFE_INACTIVE;
            explodeCount[i] = 0;
            coolCount[i] = 0;
            for (int s = 0; s < SHOTS; s++) begin
                slotValid[i][s] = 1'b0;
                slotX[i][s] = 0;
                slotY[i][s] = 0;
            end
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        resetN = 1'b1;
        updateExpect(INITIAL_X + 8, INITIAL_Y + 8);
        checkEn = 1'b1;
        setStage(2);

        // Corner cut silhouette at the start positions
        repeat (40) probeRandom();

        setStage(1);
        probeFrame();
        setStage(4);
        probeFrame();
        setStage(2);
        probeFrame();

        enable = 1'b1;
        repeat (MOVE_FRAMES) begin
            frame();
            probeFrame();
        end
        if (!bounceSeen) begin
            failRun("no monster reached a screen border");
        end
        enable = 1'b0;
        repeat (3) begin
            frame();
            probeFrame();
        end
        enable = 1'b1;

        found = 1'b0;
        hitX = 0;
        hitY = 0;
        for (int i = 0; i < MONSTERS; i++) begin
            for (int s = 0; s < SHOTS; s++) begin
                if (slotValid[i][s] && !found) begin
                    hitX = slotX[i][s];
                    hitY = slotY[i][s];
                    found = 1'b1;
                end
            end
        end
        if (!found) begin
            failRun("no missile was in flight to test the player hit");
        end
        hitMissile(hitX, hitY);
        probe(hitX, hitY);

        for (int i = 0; i < MONSTERS; i++) begin
            if (modelLife[i] == LIFE_ALIVE) begin
                shoot(modelX[i] + 8, modelY[i] + 8);
            end
        end
        repeat (EXPLODE_FRAMES) begin
            frame();
            probeFrame();
        end
        for (int i = 0; i < MONSTERS; i++) begin
            if (modelLife[i] != LIFE_DEAD) begin
                failRun("the model still holds a living monster after the explosions");
            end
        end
        probeFrame();

        @(negedge clk);
        checkEn = 1'b0;
        @(negedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* monsterGroup.f */
monsterPkg.sv
frameTimer.sv
monsterLife.sv
monsterMotion.sv
spriteWindow.sv
monsterMissiles.sv
monsterGroup.sv
monsterGroupTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the monsterGroup testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f monsterGroup.f \
    --top-module monsterGroupTb -o monsterGroupSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/monsterGroupSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
echo "Simulation did not pass"
exit 1
